//--- hw/undo_pkg.sv
package undo_pkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Sizes
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   localparam int N_THREADS                     = 4; // Logging cores.
   localparam int UNDO_LOG_THREADS              = 2; // Concurrent restores.
   localparam int LOG_CQ_SLICE_SIZE             = 3;
   localparam int LOG_UNDO_LOG_ENTRIES_PER_TASK = 2;
   localparam int LOG_MEM_WORDS                 = 8;
   localparam int LOG_MEM_RESP_DEPTH            = 2;

   localparam int LOG_N_THREADS    = $clog2(N_THREADS);
   localparam int CQ_SLOTS         = 2**LOG_CQ_SLICE_SIZE;
   localparam int ENTRIES_PER_TASK = 2**LOG_UNDO_LOG_ENTRIES_PER_TASK;
   localparam int UNDO_LOG_ENTRIES = CQ_SLOTS * ENTRIES_PER_TASK;
   localparam int MEM_WORDS        = 2**LOG_MEM_WORDS;
   localparam int MEM_RESP_DEPTH   = 2**LOG_MEM_RESP_DEPTH;

   typedef logic [LOG_CQ_SLICE_SIZE-1:0]             cq_slice_slot_t;
   typedef logic [LOG_UNDO_LOG_ENTRIES_PER_TASK-1:0] undo_id_t;
   typedef logic [LOG_MEM_WORDS-1:0]                 undo_log_addr_t;
   typedef logic [31:0]                              undo_log_data_t;
   typedef logic [$clog2(UNDO_LOG_THREADS)-1:0]      restore_thread_t;

   // One undo entry as a core presents it.
   typedef struct packed {
      cq_slice_slot_t slot;
      undo_id_t       id;
      undo_log_addr_t addr;
      undo_log_data_t data;
   } undo_entry_t;

   // Single-beat write toward the memory.
   typedef struct packed {
      undo_log_addr_t  addr;
      undo_log_data_t  data;
      restore_thread_t id; // Restore thread that issued the write.
   } mem_write_t;

   typedef struct packed {
      restore_thread_t id;
   } mem_resp_t;

   // Index of the lowest set bit, zero when no bit is set.
   function automatic logic [LOG_N_THREADS-1:0] lowest_set(input logic [N_THREADS-1:0] vec);
      logic [LOG_N_THREADS-1:0] idx;
      idx = '0;
      for (int i = N_THREADS - 1; i >= 0; i--) begin
         if (vec[i]) begin
            idx = LOG_N_THREADS'(i);
         end
      end
      return idx;
   endfunction

endpackage

//--- hw/restore_mem.sv
`timescale 1ns/1ps

module restore_mem import undo_pkg::*; (
   input  logic           clk,
   input  logic           rstn,
   input  logic           stall,

   input  logic           aw_valid,
   input  mem_write_t     aw,
   output logic           aw_ready,

   output logic           b_valid,
   output mem_resp_t      b,
   input  logic           b_ready,

   input  undo_log_addr_t dbg_addr,
   output undo_log_data_t dbg_data
);

   undo_log_data_t                mem    [MEM_WORDS];
   mem_resp_t                     resp_q [MEM_RESP_DEPTH];
   logic [LOG_MEM_RESP_DEPTH-1:0] wr_ptr;
   logic [LOG_MEM_RESP_DEPTH-1:0] rd_ptr;
   logic [LOG_MEM_RESP_DEPTH:0]   count;
   logic                          push;
   logic                          pop;

   // A full response queue holds off new writes.
   assign aw_ready = !stall && (count != MEM_RESP_DEPTH);
   assign push     = aw_valid && aw_ready;

   assign b_valid = (count != '0);
   assign b       = resp_q[rd_ptr];
   assign pop     = b_valid && b_ready;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Word storage
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int w = 0; w < MEM_WORDS; w++) begin
            mem[w] <= '0;
         end
      end else if (push) begin
         mem[aw.addr] <= aw.data;
      end
   end

   always_ff @(posedge clk) begin
      dbg_data <= mem[dbg_addr]; // One cycle of read latency.
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Response FIFO
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_ff @(posedge clk) begin
      if (push) begin
         resp_q[wr_ptr] <= '{id: aw.id};
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // The count stays within the depth and agrees with the pointer distance.
   a_fifo_no_overflow: assert property (@(posedge clk) disable iff (!rstn)
      count <= MEM_RESP_DEPTH && (wr_ptr - rd_ptr) == count[LOG_MEM_RESP_DEPTH-1:0]);

endmodule

//--- hw/undo_log.sv
`timescale 1ns/1ps

module undo_log import undo_pkg::*; (
   input  logic                                  clk,
   input  logic                                  rstn,

   input  logic           [N_THREADS-1:0]        log_valid,
   input  undo_entry_t    [N_THREADS-1:0]        log_entry,
   output logic           [N_THREADS-1:0]        log_ready,

   output logic           [UNDO_LOG_THREADS-1:0] restore_arvalid,
   input  logic           [UNDO_LOG_THREADS-1:0] restore_rvalid,
   input  cq_slice_slot_t                        restore_cq_slot,
   output logic           [UNDO_LOG_THREADS-1:0] restore_done_valid,
   output cq_slice_slot_t [UNDO_LOG_THREADS-1:0] restore_done_slot,
   input  logic           [UNDO_LOG_THREADS-1:0] restore_done_ready,

   output logic                                  mem_aw_valid,
   output mem_write_t                            mem_aw,
   input  logic                                  mem_aw_ready,
   input  logic                                  mem_b_valid,
   input  mem_resp_t                             mem_b,
   output logic                                  mem_b_ready
);

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Log capture
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   logic [LOG_N_THREADS-1:0] sel_core;
   logic                     sel_valid;
   undo_entry_t              sel_entry;

   // Entries are indexed by {slot, id}.
   undo_log_addr_t addr_log [UNDO_LOG_ENTRIES];
   undo_log_data_t data_log [UNDO_LOG_ENTRIES];
   undo_id_t       last_id  [CQ_SLOTS];

   assign sel_core  = lowest_set(log_valid);
   assign sel_valid = |log_valid;
   assign sel_entry = log_entry[sel_core];

   always_comb begin
      for (int c = 0; c < N_THREADS; c++) begin
         log_ready[c] = sel_valid && (sel_core == c);
      end
   end

   always_ff @(posedge clk) begin
      if (sel_valid) begin
         addr_log[{sel_entry.slot, sel_entry.id}] <= sel_entry.addr;
         data_log[{sel_entry.slot, sel_entry.id}] <= sel_entry.data;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int s = 0; s < CQ_SLOTS; s++) begin
            last_id[s] <= '0;
         end
      end else if (sel_valid) begin
         last_id[sel_entry.slot] <= sel_entry.id; // Ids arrive in ascending order.
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Restore engine
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   typedef enum logic [1:0] {RST_IDLE, RST_READ_LOG, RST_WRITE_MEM} restore_state_t;
   typedef enum logic {ACK_IDLE, ACK_HOLD} ack_state_t;

   restore_state_t                         state;
   ack_state_t                             ack_state;
   logic [UNDO_LOG_THREADS-1:0]            busy;
   cq_slice_slot_t [UNDO_LOG_THREADS-1:0]  thread_slot;
   logic [$clog2(ENTRIES_PER_TASK):0]      outstanding [UNDO_LOG_THREADS];
   logic [N_THREADS-1:0]                   free_vec;
   logic                                   any_free;
   logic                                   start;
   logic                                   b_fire;
   restore_thread_t                        free_thread;
   restore_thread_t                        cur_thread;
   restore_thread_t                        ack_thread;
   cq_slice_slot_t                         cur_slot;
   undo_id_t                               cur_id;
   undo_log_addr_t                         rd_addr;
   undo_log_data_t                         rd_data;

   assign free_vec    = {{(N_THREADS - UNDO_LOG_THREADS){1'b0}}, ~busy};
   assign free_thread = restore_thread_t'(lowest_set(free_vec));
   assign any_free    = ~&busy;

   always_comb begin
      for (int t = 0; t < UNDO_LOG_THREADS; t++) begin
         restore_arvalid[t]    = (state == RST_IDLE) && any_free && (free_thread == t);
         restore_done_valid[t] = (ack_state == ACK_HOLD) && (ack_thread == t);
      end
   end

   assign restore_done_slot = thread_slot;
   assign start             = |(restore_arvalid & restore_rvalid);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= RST_IDLE;
      end else begin
         case (state)
            RST_IDLE: begin
               if (start) begin
                  state <= RST_READ_LOG;
               end
            end
            RST_READ_LOG: begin
               state <= RST_WRITE_MEM;
            end
            RST_WRITE_MEM: begin
               if (mem_aw_ready) begin
                  state <= (cur_id == '0) ? RST_IDLE : RST_READ_LOG;
               end
            end
            default: begin
               state <= RST_IDLE;
            end
         endcase
      end
   end

   // The walk runs from the last id down to 0, so the oldest value lands last.
   always_ff @(posedge clk) begin
      if (start) begin
         cur_slot                 <= restore_cq_slot;
         cur_id                   <= last_id[restore_cq_slot];
         cur_thread               <= free_thread;
         thread_slot[free_thread] <= restore_cq_slot;
      end else if ((state == RST_WRITE_MEM) && mem_aw_ready) begin
         cur_id <= cur_id - 1'b1;
      end
      if (state == RST_READ_LOG) begin
         rd_addr <= addr_log[{cur_slot, cur_id}];
         rd_data <= data_log[{cur_slot, cur_id}];
      end
   end

   assign mem_aw_valid = (state == RST_WRITE_MEM);
   assign mem_aw       = '{addr: rd_addr, data: rd_data, id: cur_thread};

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Write responses and done reporting
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   assign mem_b_ready = (ack_state == ACK_IDLE); // Responses wait while a done is pending.
   assign b_fire      = mem_b_valid && mem_b_ready;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         busy       <= '0;
         ack_state  <= ACK_IDLE;
         ack_thread <= '0;
         for (int t = 0; t < UNDO_LOG_THREADS; t++) begin
            outstanding[t] <= '0;
         end
      end else begin
         if (b_fire) begin
            outstanding[mem_b.id] <= outstanding[mem_b.id] - 1'b1;
         end
         if (start) begin
            busy[free_thread]        <= 1'b1;
            outstanding[free_thread] <= {1'b0, last_id[restore_cq_slot]} + 1'b1;
         end
         case (ack_state)
            ACK_IDLE: begin
               if (b_fire && (outstanding[mem_b.id] == 1)) begin
                  ack_state  <= ACK_HOLD;
                  ack_thread <= mem_b.id;
               end
            end
            ACK_HOLD: begin
               if (restore_done_ready[ack_thread]) begin
                  ack_state        <= ACK_IDLE;
                  busy[ack_thread] <= 1'b0; // Offered again from the next cycle.
               end
            end
            default: begin
               ack_state <= ACK_IDLE;
            end
         endcase
      end
   end

   // Ready goes to the lowest valid core only, or to none.
   a_log_ready_onehot: assert property (@(posedge clk) disable iff (!rstn)
      log_ready == (log_valid & (~log_valid + 1'b1)));

   a_aw_stable: assert property (@(posedge clk) disable iff (!rstn)
      mem_aw_valid && !mem_aw_ready |=> mem_aw_valid && $stable(mem_aw));

   // Every response must belong to a restore that still expects one.
   a_resp_expected: assert property (@(posedge clk) disable iff (!rstn)
      b_fire |-> outstanding[mem_b.id] != '0);

endmodule

//--- hw/undo_subsys.sv
`timescale 1ns/1ps

module undo_subsys import undo_pkg::*; (
   input  logic                                  clk,
   input  logic                                  rstn,

   input  logic           [N_THREADS-1:0]        log_valid,
   input  undo_entry_t    [N_THREADS-1:0]        log_entry,
   output logic           [N_THREADS-1:0]        log_ready,

   output logic           [UNDO_LOG_THREADS-1:0] restore_arvalid,
   input  logic           [UNDO_LOG_THREADS-1:0] restore_rvalid,
   input  cq_slice_slot_t                        restore_cq_slot,
   output logic           [UNDO_LOG_THREADS-1:0] restore_done_valid,
   output cq_slice_slot_t [UNDO_LOG_THREADS-1:0] restore_done_slot,
   input  logic           [UNDO_LOG_THREADS-1:0] restore_done_ready,

   input  logic                                  mem_stall,
   input  undo_log_addr_t                        dbg_addr,
   output undo_log_data_t                        dbg_data
);

   // Internal channel between the log and the memory.
   logic       mem_aw_valid;
   logic       mem_aw_ready;
   mem_write_t mem_aw;
   logic       mem_b_valid;
   logic       mem_b_ready;
   mem_resp_t  mem_b;

   undo_log LOG (
      .clk                (clk),
      .rstn               (rstn),
      .log_valid          (log_valid),
      .log_entry          (log_entry),
      .log_ready          (log_ready),
      .restore_arvalid    (restore_arvalid),
      .restore_rvalid     (restore_rvalid),
      .restore_cq_slot    (restore_cq_slot),
      .restore_done_valid (restore_done_valid),
      .restore_done_slot  (restore_done_slot),
      .restore_done_ready (restore_done_ready),
      .mem_aw_valid       (mem_aw_valid),
      .mem_aw             (mem_aw),
      .mem_aw_ready       (mem_aw_ready),
      .mem_b_valid        (mem_b_valid),
      .mem_b              (mem_b),
      .mem_b_ready        (mem_b_ready)
   );

   restore_mem MEM (
      .clk      (clk),
      .rstn     (rstn),
      .stall    (mem_stall),
      .aw_valid (mem_aw_valid),
      .aw       (mem_aw),
      .aw_ready (mem_aw_ready),
      .b_valid  (mem_b_valid),
      .b        (mem_b),
      .b_ready  (mem_b_ready),
      .dbg_addr (dbg_addr),
      .dbg_data (dbg_data)
   );

endmodule

//--- verification/tb_undo_subsys.sv
`timescale 1ns/1ps

module tb_undo_subsys import undo_pkg::*; ();

   localparam int          TIMEOUT = 200;
   localparam int unsigned SEED    = 32'ha54262a4;

   typedef enum {OP_STAGE, OP_PUSH, OP_RESTORE, OP_RESTORE_PAIR, OP_VERIFY, OP_STALL} op_t;

   // Restore rows use slot, pair rows take the second slot from expected.
   typedef struct {
      op_t            op;
      int             core;
      cq_slice_slot_t slot;
      undo_id_t       id;
      undo_log_addr_t addr;
      undo_log_data_t data;
      int             expected;
   } row_t;

   logic                                  clk;
   logic                                  rstn;
   logic           [N_THREADS-1:0]        log_valid;
   undo_entry_t    [N_THREADS-1:0]        log_entry;
   logic           [N_THREADS-1:0]        log_ready;
   logic           [UNDO_LOG_THREADS-1:0] restore_arvalid;
   logic           [UNDO_LOG_THREADS-1:0] restore_rvalid;
   cq_slice_slot_t                        restore_cq_slot;
   logic           [UNDO_LOG_THREADS-1:0] restore_done_valid;
   cq_slice_slot_t [UNDO_LOG_THREADS-1:0] restore_done_slot;
   logic           [UNDO_LOG_THREADS-1:0] restore_done_ready;
   logic                                  mem_stall;
   undo_log_addr_t                        dbg_addr;
   undo_log_data_t                        dbg_data;

   row_t                                  table_q [$];
   logic           [N_THREADS-1:0]        staged_valid;
   undo_entry_t    [N_THREADS-1:0]        staged_entry;
   logic           [UNDO_LOG_THREADS-1:0] tb_busy;
   cq_slice_slot_t [UNDO_LOG_THREADS-1:0] tb_slot;
   undo_log_addr_t                        m_addr [CQ_SLOTS][ENTRIES_PER_TASK];
   undo_log_data_t                        m_data [CQ_SLOTS][ENTRIES_PER_TASK];
   int                                    m_last [CQ_SLOTS];
   undo_log_data_t                        mem_model [MEM_WORDS];
   logic                                  stall_en;
   int                                    errors;
   int                                    checks;

   undo_subsys UUT (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Random back-pressure on the memory write channel.
   initial begin
      mem_stall = 1'b0;
      forever begin
         @(posedge clk);
         #1 mem_stall = stall_en ? 1'($urandom_range(0, 1)) : 1'b0;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Compare tasks and run control
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   task automatic check_data(string name, undo_log_data_t got, undo_log_data_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
      end
   endtask

   task automatic check_slot(string name, cq_slice_slot_t got, cq_slice_slot_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
      end
   endtask

   task automatic check_bit(string name, logic got, logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   task automatic finish_run();
      $display("Summary: %0d tests, %0d checks, %0d errors", table_q.size() + 1, checks, errors);
      if (errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   endtask

   task automatic report_timeout(string what);
      errors++;
      $display("Timeout at %0t while waiting for %s", $time, what);
      finish_run();
   endtask

   function automatic void add_row(op_t op, int core, int slot, int id, int addr,
                                   logic [31:0] data, int expected);
      row_t r;
      r = '{op, core, cq_slice_slot_t'(slot), undo_id_t'(id), undo_log_addr_t'(addr),
            data, expected};
      table_q.push_back(r);
   endfunction

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Stimulus tasks
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   task automatic push_staged();
      logic [N_THREADS-1:0] accepted;
      logic [N_THREADS-1:0] exp_ready;
      logic [N_THREADS-1:0] seen;
      int                   cycles;
      accepted  = '0;
      cycles    = 0;
      log_valid = staged_valid;
      log_entry = staged_entry;
      while (log_valid != '0) begin
         @(negedge clk);
         exp_ready = log_valid & (~log_valid + 1'b1); // Isolates the lowest valid core.
         seen      = log_ready;
         for (int c = 0; c < N_THREADS; c++) begin
            check_bit($sformatf("log_ready[%0d]", c), seen[c], exp_ready[c]);
            if (seen[c]) begin
               m_addr[log_entry[c].slot][log_entry[c].id] = log_entry[c].addr;
               m_data[log_entry[c].slot][log_entry[c].id] = log_entry[c].data;
               m_last[log_entry[c].slot] = int'(log_entry[c].id);
            end
         end
         accepted = accepted | seen;
         cycles++;
         if (cycles > TIMEOUT) begin
            report_timeout("log_ready");
         end
         @(posedge clk);
         #1 log_valid = log_valid & ~seen;
      end
      check_bit("all staged entries accepted", accepted == staged_valid, 1'b1);
      staged_valid = '0;
   endtask

   task automatic issue_restore(cq_slice_slot_t slot, output int thread);
      int cycles;
      cycles = 0;
      @(negedge clk);
      while (restore_arvalid == '0) begin
         cycles++;
         if (cycles > TIMEOUT) begin
            report_timeout("restore_arvalid");
         end
         @(negedge clk);
      end
      thread = tb_busy[0] ? 1 : 0; // Lowest free thread is offered.
      for (int t = 0; t < UNDO_LOG_THREADS; t++) begin
         check_bit($sformatf("restore_arvalid[%0d]", t), restore_arvalid[t], t == thread);
      end
      @(posedge clk);
      #1;
      restore_rvalid[thread] = 1'b1;
      restore_cq_slot        = slot;
      @(posedge clk);
      #1 restore_rvalid = '0;
      tb_busy[thread] = 1'b1;
      tb_slot[thread] = slot;
      for (int i = m_last[slot]; i >= 0; i--) begin
         mem_model[m_addr[slot][i]] = m_data[slot][i];
      end
   endtask

   task automatic collect_done(logic [UNDO_LOG_THREADS-1:0] pending);
      int cycles;
      int delay;
      cycles = 0;
      while (pending != '0) begin
         @(negedge clk);
         for (int t = 0; t < UNDO_LOG_THREADS; t++) begin
            if (!pending[t]) begin
               check_bit($sformatf("restore_done_valid[%0d]", t), restore_done_valid[t], 1'b0);
            end else if (restore_done_valid[t]) begin
               check_slot($sformatf("restore_done_slot[%0d]", t), restore_done_slot[t],
                          tb_slot[t]);
               delay = int'($urandom_range(0, 3));
               repeat (delay) begin
                  @(negedge clk);
                  check_bit("restore_done_valid held", restore_done_valid[t], 1'b1);
               end
               @(posedge clk);
               #1 restore_done_ready[t] = 1'b1;
               @(negedge clk);
               check_bit("restore_done_valid at ready", restore_done_valid[t], 1'b1);
               @(posedge clk);
               #1 restore_done_ready[t] = 1'b0;
               @(negedge clk);
               check_bit("restore_done_valid after ready", restore_done_valid[t], 1'b0);
               pending[t] = 1'b0;
               tb_busy[t] = 1'b0;
               cycles     = 0;
            end
         end
         cycles++;
         if (cycles > TIMEOUT) begin
            report_timeout("restore_done_valid");
         end
      end
   endtask

   task automatic verify_memory();
      for (int a = 0; a < MEM_WORDS; a++) begin
         @(posedge clk);
         #1 dbg_addr = undo_log_addr_t'(a);
         @(posedge clk);
         @(negedge clk);
         check_data($sformatf("dbg_data[0x%02h]", a), dbg_data, mem_model[a]);
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Stimulus table and main sequence
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   initial begin
      row_t                        r;
      int                          errs_before;
      int                          thr_a;
      int                          thr_b;
      logic [UNDO_LOG_THREADS-1:0] pend;
      void'($urandom(SEED));
      rstn               = 1'b0;
      log_valid          = '0;
      log_entry          = '0;
      restore_rvalid     = '0;
      restore_cq_slot    = '0;
      restore_done_ready = '0;
      dbg_addr           = '0;
      stall_en           = 1'b0;
      staged_valid       = '0;
      staged_entry       = '0;
      tb_busy            = '0;
      tb_slot            = '0;
      errors             = 0;
      checks             = 0;
      for (int a = 0; a < MEM_WORDS; a++) begin
         mem_model[a] = '0;
      end
      add_row(OP_STAGE, 0, 1, 0, 'h10, 32'h1111_0000, 0);
      add_row(OP_STAGE, 1, 1, 1, 'h11, 32'h1111_0001, 0);
      add_row(OP_STAGE, 2, 2, 0, 'h20, 32'h2222_0000, 0);
      add_row(OP_STAGE, 3, 1, 2, 'h10, 32'h1111_0002, 0); // Same address as id 0.
      add_row(OP_PUSH, 0, 0, 0, 0, 32'h0, 0);
      add_row(OP_RESTORE, 0, 1, 0, 0, 32'h0, 0);
      add_row(OP_VERIFY, 0, 0, 0, 0, 32'h0, 0);
      add_row(OP_STAGE, 1, 2, 1, 'h21, 32'h2222_0001, 0);
      add_row(OP_STAGE, 2, 3, 0, 'h30, 32'h3333_0000, 0);
      add_row(OP_STAGE, 3, 3, 1, 'h20, 32'h3333_0001, 0);
      add_row(OP_PUSH, 0, 0, 0, 0, 32'h0, 0);
      add_row(OP_STALL, 0, 0, 0, 0, 32'h0, 1);
      add_row(OP_RESTORE_PAIR, 0, 2, 0, 0, 32'h0, 3);
      add_row(OP_VERIFY, 0, 0, 0, 0, 32'h0, 0);
      add_row(OP_STAGE, 0, 5, 0, 'h50, 32'h5555_0000, 0);
      add_row(OP_STAGE, 1, 5, 1, 'h51, 32'h5555_0001, 0);
      add_row(OP_STAGE, 2, 5, 2, 'h50, 32'h5555_0002, 0);
      add_row(OP_STAGE, 3, 5, 3, 'h52, 32'h5555_0003, 0);
      add_row(OP_PUSH, 0, 0, 0, 0, 32'h0, 0);
      add_row(OP_RESTORE, 0, 5, 0, 0, 32'h0, 0);
      add_row(OP_VERIFY, 0, 0, 0, 0, 32'h0, 0);
      add_row(OP_STALL, 0, 0, 0, 0, 32'h0, 0);
      add_row(OP_RESTORE_PAIR, 0, 5, 0, 0, 32'h0, 1);
      add_row(OP_VERIFY, 0, 0, 0, 0, 32'h0, 0);

      repeat (3) @(posedge clk);
      #1 rstn = 1'b1;
      @(negedge clk);
      check_bit("log_ready any", |log_ready, 1'b0);
      check_bit("restore_done_valid any", |restore_done_valid, 1'b0);
      check_bit("restore_arvalid[0]", restore_arvalid[0], 1'b1);
      check_bit("restore_arvalid[1]", restore_arvalid[1], 1'b0);
      $display("test 0 RESET: %s", (errors == 0) ? "ok" : "errors");

      foreach (table_q[i]) begin
         r           = table_q[i];
         errs_before = errors;
         case (r.op)
            OP_STAGE: begin
               staged_valid[r.core] = 1'b1;
               staged_entry[r.core] = '{slot: r.slot, id: r.id, addr: r.addr, data: r.data};
            end
            OP_PUSH: begin
               @(posedge clk);
               #1 push_staged();
            end
            OP_RESTORE: begin
               issue_restore(r.slot, thr_a);
               pend        = '0;
               pend[thr_a] = 1'b1;
               collect_done(pend);
            end
            OP_RESTORE_PAIR: begin
               issue_restore(r.slot, thr_a);
               issue_restore(cq_slice_slot_t'(r.expected), thr_b);
               pend        = '0;
               pend[thr_a] = 1'b1;
               pend[thr_b] = 1'b1;
               collect_done(pend);
            end
            OP_VERIFY: verify_memory();
            default:   stall_en = (r.expected != 0);
         endcase
         $display("test %0d %s: %s", i + 1, r.op.name(), (errors == errs_before) ? "ok" : "errors");
      end
      finish_run();
   end

endmodule

//--- src.f
hw/undo_pkg.sv
hw/restore_mem.sv
hw/undo_log.sv
hw/undo_subsys.sv
verification/tb_undo_subsys.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f src.f \
   --top-module tb_undo_subsys -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || echo "Simulation FAILED" >> sim.log
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
   exit 1
fi
exit 0
